// ==== capi_response_pkg.sv ====
package capi_response_pkg;

  // Command type recorded per tag when the command is issued
  typedef enum logic [2:0] {
    CMD_INVALID = 3'd0,
    CMD_READ    = 3'd1,
    CMD_WRITE   = 3'd2,
    CMD_WED     = 3'd3,
    CMD_RESTART = 3'd4
  } cmd_type_t;

  typedef enum logic [7:0] {
    RSP_DONE    = 8'd0,
    RSP_AERROR  = 8'd1,
    RSP_DERROR  = 8'd3,
    RSP_NLOCK   = 8'd4,
    RSP_NRES    = 8'd5,
    RSP_FLUSHED = 8'd6,
    RSP_FAULT   = 8'd7,
    RSP_FAILED  = 8'd8,
    RSP_PAGED   = 8'd10
  } response_code_t;

  typedef struct packed {
    logic           valid;
    logic [7:0]     tag;
    logic           tag_parity;
    response_code_t response;
  } response_in_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] tag;
    cmd_type_t  cmd_type;
    logic [7:0] cu_id;
  } command_issue_t;

  typedef struct packed {
    cmd_type_t  cmd_type;
    logic [7:0] cu_id;
  } command_tag_line_t;

  typedef struct packed {
    logic           valid;
    logic [7:0]     tag;
    logic [7:0]     cu_id;
    cmd_type_t      cmd_type;
    response_code_t response;
  } response_line_t;

  typedef struct packed {
    logic           read_response;
    logic           write_response;
    logic           wed_response;
    logic           restart_response;
    response_line_t response;
  } response_control_out_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite register port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axi_lite_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axi_lite_rsp_t;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  localparam logic [7:0] REG_CONTROL       = 8'h00;
  localparam logic [7:0] REG_ERRORS        = 8'h04;
  localparam logic [7:0] REG_READ_COUNT    = 8'h08;
  localparam logic [7:0] REG_WRITE_COUNT   = 8'h0C;
  localparam logic [7:0] REG_WED_COUNT     = 8'h10;
  localparam logic [7:0] REG_RESTART_COUNT = 8'h14;
  localparam logic [7:0] REG_LAST_RESPONSE = 8'h18;

  // Bit that gives the tag plus itself an odd number of ones
  function automatic logic odd_parity_of(input logic [7:0] tag);
    return ~(^tag);
  endfunction

  // One-hot code error, index 0 is AERROR through index 5 for FAILED
  function automatic logic [0:5] cmd_response_error_type(input response_code_t code);
    logic [0:5] error_bits;
    error_bits = 6'b000000;
    case (code)
      RSP_AERROR: error_bits[0] = 1'b1;
      RSP_DERROR: error_bits[1] = 1'b1;
      RSP_NLOCK:  error_bits[2] = 1'b1;
      RSP_NRES:   error_bits[3] = 1'b1;
      RSP_FAULT:  error_bits[4] = 1'b1;
      RSP_FAILED: error_bits[5] = 1'b1;
      default:    error_bits = 6'b000000;
    endcase
    return error_bits;
  endfunction

endpackage

// ==== command_tag_table.sv ====
`timescale 1ns/1ps

module command_tag_table #(
  parameter int TAG_COUNT = 256
) (
  input  logic                                 clock,
  input  logic                                 rstn,
  input  capi_response_pkg::command_issue_t    command_issue,
  input  capi_response_pkg::response_in_t      response,
  output capi_response_pkg::command_tag_line_t tag_line
);

  localparam int TAG_BITS = $clog2(TAG_COUNT);

  logic [TAG_BITS-1:0]                   issue_index;
  logic [TAG_BITS-1:0]                   response_index;
  logic [TAG_COUNT-1:0]                  busy;
  capi_response_pkg::command_tag_line_t  table_mem [TAG_COUNT];

  // Tags above TAG_COUNT fold onto the low index bits
  assign issue_index    = command_issue.tag[TAG_BITS-1:0];
  assign response_index = response.tag[TAG_BITS-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Entry storage and busy tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (command_issue.valid) begin
      table_mem[issue_index].cmd_type <= command_issue.cmd_type;
      table_mem[issue_index].cu_id    <= command_issue.cu_id;
    end
  end

  // A response releases its tag, and an issue in the same cycle claims it again
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy <= '0;
    end else begin
      if (response.valid) begin
        busy[response_index] <= 1'b0;
      end
      if (command_issue.valid) begin
        busy[issue_index] <= 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookup on response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The read lines up with the latched response in response_control
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_line <= '0;
    end else if (response.valid) begin
      if (busy[response_index]) begin
        tag_line <= table_mem[response_index];
      end else begin
        tag_line.cmd_type <= capi_response_pkg::CMD_INVALID;
        tag_line.cu_id    <= '0;
      end
    end
  end

  // Command side must wait for the response before reusing a tag
  issue_to_free_tag : assert property (
    @(posedge clock) disable iff (!rstn)
    command_issue.valid |->
      !busy[issue_index] || (response.valid && response_index == issue_index)
  ) else $error("command issued to busy tag %0d", command_issue.tag);

endmodule

// ==== response_control.sv ====
`timescale 1ns/1ps

module response_control (
  input  logic                                     clock,
  input  logic                                     rstn,
  input  logic                                     enabled,
  input  logic                                     error_enable,
  input  capi_response_pkg::response_in_t          response,
  input  capi_response_pkg::command_tag_line_t     tag_line,
  output logic [0:6]                               response_error,
  output capi_response_pkg::response_control_out_t response_control_out
);

  capi_response_pkg::response_in_t response_in;

  logic       tag_parity_error;
  logic [0:5] cmd_response_error;
  logic [0:6] detected_errors;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input latch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      response_in <= '0;
    end else if (enabled && response.valid) begin
      response_in <= response;
    end else begin
      response_in <= '0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Routing by command type
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // An unknown tag still passes its line through, just with no class flag
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      response_control_out <= '0;
    end else if (enabled && response_in.valid) begin
      response_control_out.read_response    <= 1'b0;
      response_control_out.write_response   <= 1'b0;
      response_control_out.wed_response     <= 1'b0;
      response_control_out.restart_response <= 1'b0;
      case (tag_line.cmd_type)
        capi_response_pkg::CMD_READ:    response_control_out.read_response    <= 1'b1;
        capi_response_pkg::CMD_WRITE:   response_control_out.write_response   <= 1'b1;
        capi_response_pkg::CMD_WED:     response_control_out.wed_response     <= 1'b1;
        capi_response_pkg::CMD_RESTART: response_control_out.restart_response <= 1'b1;
        default: ;
      endcase
      response_control_out.response.valid    <= 1'b1;
      response_control_out.response.tag      <= response_in.tag;
      response_control_out.response.cu_id    <= tag_line.cu_id;
      response_control_out.response.cmd_type <= tag_line.cmd_type;
      response_control_out.response.response <= response_in.response;
    end else begin
      response_control_out <= '0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Error pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Parity and code checks, then the combined vector, then the enable gate
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_parity_error   <= 1'b0;
      cmd_response_error <= '0;
      detected_errors    <= '0;
    end else begin
      tag_parity_error <= response_in.valid &&
        (response_in.tag_parity != capi_response_pkg::odd_parity_of(response_in.tag));
      if (response_in.valid) begin
        cmd_response_error <= capi_response_pkg::cmd_response_error_type(response_in.response);
      end else begin
        cmd_response_error <= '0;
      end
      detected_errors <= {tag_parity_error, cmd_response_error};
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      response_error <= '0;
    end else if (error_enable) begin
      response_error <= detected_errors;
    end else begin
      response_error <= '0;
    end
  end

  // Downstream buffers expect a single destination per response
  class_flags_onehot : assert property (
    @(posedge clock) disable iff (!rstn)
    $onehot0({response_control_out.read_response, response_control_out.write_response,
              response_control_out.wed_response, response_control_out.restart_response})
  ) else $error("more than one response class flag set");

endmodule

// ==== capi_status_regs.sv ====
`timescale 1ns/1ps

module capi_status_regs (
  input  logic                                     clock,
  input  logic                                     rstn,
  input  capi_response_pkg::axi_lite_req_t         axi_req,
  output capi_response_pkg::axi_lite_rsp_t         axi_rsp,
  input  capi_response_pkg::response_control_out_t response_control_out,
  input  logic [0:6]                               response_error,
  output logic                                     enabled,
  output logic                                     error_enable
);

  logic                              write_hs;
  logic                              read_hs;
  logic                              bvalid;
  logic                              rvalid;
  logic [31:0]                       rdata;
  logic [31:0]                       read_value;
  logic [6:0]                        sticky_errors;
  logic [6:0]                        error_clear;
  logic [3:0]                        class_flags;
  logic [31:0]                       class_count [4];
  capi_response_pkg::response_line_t last_response;

  // Address and data are taken together, one write in flight
  assign write_hs = axi_req.awvalid && axi_req.wvalid && !bvalid;
  assign read_hs  = axi_req.arvalid && !rvalid;

  // Index 0 is the read class, up to index 3 for restart
  assign class_flags = {response_control_out.restart_response, response_control_out.wed_response,
                        response_control_out.write_response, response_control_out.read_response};

  assign error_clear = (write_hs && axi_req.awaddr == capi_response_pkg::REG_ERRORS &&
                        axi_req.wstrb[0]) ? axi_req.wdata[6:0] : 7'd0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled      <= 1'b0;
      error_enable <= 1'b0;
    end else if (write_hs && axi_req.awaddr == capi_response_pkg::REG_CONTROL &&
                 axi_req.wstrb[0]) begin
      enabled      <= axi_req.wdata[0];
      error_enable <= axi_req.wdata[1];
    end
  end

  // A new error in the same cycle as a clear stays set
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      sticky_errors <= '0;
    end else begin
      for (int i = 0; i < 7; i++) begin
        if (response_error[i]) begin
          sticky_errors[i] <= 1'b1;
        end else if (error_clear[i]) begin
          sticky_errors[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 4; i++) begin
        class_count[i] <= '0;
      end
      last_response <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (class_flags[i]) begin
          class_count[i] <= class_count[i] + 32'd1;
        end
      end
      if (|class_flags) begin
        last_response <= response_control_out.response;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite channels
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    read_value = '0;
    case (axi_req.araddr)
      capi_response_pkg::REG_CONTROL:       read_value = {30'd0, error_enable, enabled};
      capi_response_pkg::REG_ERRORS:        read_value = {25'd0, sticky_errors};
      capi_response_pkg::REG_READ_COUNT:    read_value = class_count[0];
      capi_response_pkg::REG_WRITE_COUNT:   read_value = class_count[1];
      capi_response_pkg::REG_WED_COUNT:     read_value = class_count[2];
      capi_response_pkg::REG_RESTART_COUNT: read_value = class_count[3];
      capi_response_pkg::REG_LAST_RESPONSE: begin
        read_value = {last_response.response, 5'd0, last_response.cmd_type,
                      last_response.cu_id, last_response.tag};
      end
      default: read_value = '0;
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      rdata  <= '0;
    end else begin
      if (write_hs) begin
        bvalid <= 1'b1;
      end else if (axi_req.bready) begin
        bvalid <= 1'b0;
      end
      if (read_hs) begin
        rvalid <= 1'b1;
        rdata  <= read_value;
      end else if (axi_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    axi_rsp         = '0;
    axi_rsp.awready = write_hs;
    axi_rsp.wready  = write_hs;
    axi_rsp.bvalid  = bvalid;
    axi_rsp.bresp   = capi_response_pkg::AXI_RESP_OKAY;
    axi_rsp.arready = !rvalid;
    axi_rsp.rvalid  = rvalid;
    axi_rsp.rdata   = rdata;
    axi_rsp.rresp   = capi_response_pkg::AXI_RESP_OKAY;
  end

  bvalid_held : assert property (
    @(posedge clock) disable iff (!rstn)
    bvalid && !axi_req.bready |=> bvalid
  ) else $error("bvalid dropped before bready");

  rvalid_held : assert property (
    @(posedge clock) disable iff (!rstn)
    rvalid && !axi_req.rready |=> rvalid && $stable(rdata)
  ) else $error("read data changed before rready");

endmodule

// ==== capi_response_top.sv ====
`timescale 1ns/1ps

module capi_response_top #(
  parameter int TAG_COUNT = 256
) (
  input  logic                                     clock,
  input  logic                                     rstn,
  input  capi_response_pkg::command_issue_t        command_issue,
  input  capi_response_pkg::response_in_t          response,
  input  capi_response_pkg::axi_lite_req_t         axi_req,
  output capi_response_pkg::axi_lite_rsp_t         axi_rsp,
  output capi_response_pkg::response_control_out_t response_control_out,
  output logic [0:6]                               response_error
);

  capi_response_pkg::command_tag_line_t tag_line;
  logic                                 enabled;
  logic                                 error_enable;

  command_tag_table #(
    .TAG_COUNT(TAG_COUNT)
  ) command_tag_table_inst (
    .clock         (clock),
    .rstn          (rstn),
    .command_issue (command_issue),
    .response      (response),
    .tag_line      (tag_line)
  );

  response_control response_control_inst (
    .clock                (clock),
    .rstn                 (rstn),
    .enabled              (enabled),
    .error_enable         (error_enable),
    .response             (response),
    .tag_line             (tag_line),
    .response_error       (response_error),
    .response_control_out (response_control_out)
  );

  // Counters and sticky errors watch the same outputs that leave the top
  capi_status_regs capi_status_regs_inst (
    .clock                (clock),
    .rstn                 (rstn),
    .axi_req              (axi_req),
    .axi_rsp              (axi_rsp),
    .response_control_out (response_control_out),
    .response_error       (response_error),
    .enabled              (enabled),
    .error_enable         (error_enable)
  );

endmodule

// ==== capi_response_tb.sv ====
`timescale 1ns/1ps

module capi_response_tb;

  localparam int CYCLE_LIMIT  = 3000;
  localparam int RANDOM_COUNT = 40;

  logic                                     clock;
  logic                                     rstn;
  capi_response_pkg::command_issue_t        command_issue;
  capi_response_pkg::response_in_t          response;
  capi_response_pkg::axi_lite_req_t         axi_req;
  capi_response_pkg::axi_lite_rsp_t         axi_rsp;
  capi_response_pkg::response_control_out_t response_control_out;
  logic [0:6]                               response_error;
  logic [3:0]                               observed_flags;

  int          error_count;
  int          cycle_count;
  logic [31:0] lfsr_state;
  logic [31:0] count_expected [4];

  capi_response_top #(
    .TAG_COUNT(256)
  ) DUT (
    .clock                (clock),
    .rstn                 (rstn),
    .command_issue        (command_issue),
    .response             (response),
    .axi_req              (axi_req),
    .axi_rsp              (axi_rsp),
    .response_control_out (response_control_out),
    .response_error       (response_error)
  );

  // Read class first, restart class last
  assign observed_flags = {response_control_out.read_response, response_control_out.write_response,
                           response_control_out.wed_response, response_control_out.restart_response};

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference rules and random source
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Parity bit that leaves an odd count of ones over tag and bit
  function automatic logic expected_parity(input logic [7:0] tag);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (tag[i]) ones++;
    end
    return (ones % 2) == 0;
  endfunction

  function automatic capi_response_pkg::response_code_t code_from_index(input logic [2:0] index);
    case (index)
      3'd1:    return capi_response_pkg::RSP_AERROR;
      3'd2:    return capi_response_pkg::RSP_DERROR;
      3'd3:    return capi_response_pkg::RSP_NLOCK;
      3'd4:    return capi_response_pkg::RSP_NRES;
      3'd5:    return capi_response_pkg::RSP_FAULT;
      3'd6:    return capi_response_pkg::RSP_FAILED;
      3'd7:    return capi_response_pkg::RSP_PAGED;
      default: return capi_response_pkg::RSP_DONE;
    endcase
  endfunction

  // Bit i of the result is error index i and bit 0 is tag parity
  function automatic logic [6:0] expected_code_bits(input capi_response_pkg::response_code_t code);
    case (code)
      capi_response_pkg::RSP_AERROR: return 7'b000_0010;
      capi_response_pkg::RSP_DERROR: return 7'b000_0100;
      capi_response_pkg::RSP_NLOCK:  return 7'b000_1000;
      capi_response_pkg::RSP_NRES:   return 7'b001_0000;
      capi_response_pkg::RSP_FAULT:  return 7'b010_0000;
      capi_response_pkg::RSP_FAILED: return 7'b100_0000;
      default:                       return 7'b000_0000;
    endcase
  endfunction

  function automatic logic [6:0] errors_as_bits(input logic [0:6] vector);
    logic [6:0] bits;
    for (int i = 0; i < 7; i++) begin
      bits[i] = vector[i];
    end
    return bits;
  endfunction

  function automatic logic [3:0] expected_flags(input capi_response_pkg::cmd_type_t cmd);
    case (cmd)
      capi_response_pkg::CMD_READ:    return 4'b1000;
      capi_response_pkg::CMD_WRITE:   return 4'b0100;
      capi_response_pkg::CMD_WED:     return 4'b0010;
      capi_response_pkg::CMD_RESTART: return 4'b0001;
      default:                        return 4'b0000;
    endcase
  endfunction

  function automatic logic [31:0] last_response_word(input logic [7:0] tag, input logic [7:0] cu,
      input capi_response_pkg::cmd_type_t cmd, input capi_response_pkg::response_code_t code);
    return {8'(code), 5'd0, 3'(cmd), cu, tag};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus and port drivers start and end on a falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    axi_req.awvalid = 1'b1;
    axi_req.awaddr  = addr;
    axi_req.wvalid  = 1'b1;
    axi_req.wdata   = data;
    axi_req.wstrb   = 4'hF;
    axi_req.bready  = 1'b1;
    do begin
      @(negedge clock);
    end while (!axi_rsp.bvalid);
    axi_req.awvalid = 1'b0;
    axi_req.wvalid  = 1'b0;
    check("bresp", 32'(axi_rsp.bresp), 32'(capi_response_pkg::AXI_RESP_OKAY));
    @(negedge clock);
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    axi_req.arvalid = 1'b1;
    axi_req.araddr  = addr;
    axi_req.rready  = 1'b1;
    do begin
      @(negedge clock);
    end while (!axi_rsp.rvalid);
    axi_req.arvalid = 1'b0;
    data = axi_rsp.rdata;
    check("rresp", 32'(axi_rsp.rresp), 32'(capi_response_pkg::AXI_RESP_OKAY));
    @(negedge clock);
  endtask

  task automatic expect_register(input string name, input logic [7:0] addr,
      input logic [31:0] expected);
    logic [31:0] data;
    axi_read(addr, data);
    check(name, data, expected);
  endtask

  task automatic check_counters();
    for (int i = 0; i < 4; i++) begin
      expect_register($sformatf("class counter %0d", i),
                      capi_response_pkg::REG_READ_COUNT + 8'(4 * i), count_expected[i]);
    end
  endtask

  task automatic issue_command(input logic [7:0] tag, input capi_response_pkg::cmd_type_t cmd,
      input logic [7:0] cu);
    command_issue.valid    = 1'b1;
    command_issue.tag      = tag;
    command_issue.cmd_type = cmd;
    command_issue.cu_id    = cu;
    @(negedge clock);
    command_issue.valid = 1'b0;
  endtask

  task automatic drive_response(input logic [7:0] tag,
      input capi_response_pkg::response_code_t code, input logic flip_parity);
    response.valid      = 1'b1;
    response.tag        = tag;
    response.tag_parity = expected_parity(tag) ^ flip_parity;
    response.response   = code;
  endtask

  task automatic send_response(input logic [7:0] tag,
      input capi_response_pkg::response_code_t code, input logic flip_parity);
    drive_response(tag, code, flip_parity);
    @(negedge clock);
    response.valid = 1'b0;
  endtask

  task automatic check_routed(input logic [7:0] tag, input capi_response_pkg::cmd_type_t cmd,
      input logic [7:0] cu, input capi_response_pkg::response_code_t code);
    check("class flags", 32'(observed_flags), 32'(expected_flags(cmd)));
    check("response.valid", 32'(response_control_out.response.valid), 32'd1);
    check("response.tag", 32'(response_control_out.response.tag), 32'(tag));
    check("response.cu_id", 32'(response_control_out.response.cu_id), 32'(cu));
    check("response.cmd_type", 32'(response_control_out.response.cmd_type), 32'(cmd));
    check("response.response", 32'(response_control_out.response.response), 32'(code));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_registers();
    for (int a = 0; a <= 24; a += 4) begin
      expect_register($sformatf("register %02h after reset", a), 8'(a), 32'd0);
    end
    axi_write(capi_response_pkg::REG_CONTROL, 32'd3);
    expect_register("REG_CONTROL", capi_response_pkg::REG_CONTROL, 32'd3);
    axi_write(capi_response_pkg::REG_CONTROL, 32'd2);
    expect_register("REG_CONTROL", capi_response_pkg::REG_CONTROL, 32'd2);
    // Control and the last read data are nonzero while the unmapped address is read
    expect_register("unmapped register", 8'h40, 32'd0);
    axi_write(capi_response_pkg::REG_CONTROL, 32'd0);
    expect_register("REG_CONTROL", capi_response_pkg::REG_CONTROL, 32'd0);
  endtask

  task automatic test_routing();
    logic [7:0]                   tag;
    logic [7:0]                   cu;
    capi_response_pkg::cmd_type_t cmd;
    axi_write(capi_response_pkg::REG_CONTROL, 32'd1);
    for (int i = 0; i < 4; i++) begin
      issue_command(8'h11 * 8'(i + 1), capi_response_pkg::cmd_type_t'(3'(i + 1)), 8'hA1 + 8'(i));
    end
    for (int i = 0; i < 4; i++) begin
      tag = 8'h11 * 8'(i + 1);
      cu  = 8'hA1 + 8'(i);
      cmd = capi_response_pkg::cmd_type_t'(3'(i + 1));
      send_response(tag, capi_response_pkg::RSP_DONE, 1'b0);
      @(negedge clock);
      check_routed(tag, cmd, cu, capi_response_pkg::RSP_DONE);
      count_expected[i] += 32'd1;
    end
    repeat (2) @(negedge clock);
    check_counters();
    expect_register("REG_LAST_RESPONSE", capi_response_pkg::REG_LAST_RESPONSE,
                    last_response_word(8'h44, 8'hA4, capi_response_pkg::CMD_RESTART,
                                       capi_response_pkg::RSP_DONE));
    // Tag 0x55 was never issued
    send_response(8'h55, capi_response_pkg::RSP_DONE, 1'b0);
    @(negedge clock);
    check_routed(8'h55, capi_response_pkg::CMD_INVALID, 8'h00, capi_response_pkg::RSP_DONE);
    repeat (2) @(negedge clock);
    check_counters();
  endtask

  task automatic test_error_codes();
    capi_response_pkg::response_code_t code;
    axi_write(capi_response_pkg::REG_CONTROL, 32'd3);
    for (int i = 1; i <= 6; i++) begin
      code = code_from_index(3'(i));
      send_response(8'h60 + 8'(i), code, 1'b0);
      repeat (3) @(negedge clock);
      check("response_error", 32'(errors_as_bits(response_error)), 32'(expected_code_bits(code)));
    end
    @(negedge clock);
    expect_register("REG_ERRORS", capi_response_pkg::REG_ERRORS, 32'h7E);
    axi_write(capi_response_pkg::REG_ERRORS, 32'h7F);
    expect_register("REG_ERRORS after clear", capi_response_pkg::REG_ERRORS, 32'd0);
  endtask

  task automatic test_parity();
    send_response(8'h70, capi_response_pkg::RSP_DONE, 1'b1);
    repeat (3) @(negedge clock);
    check("response_error", 32'(errors_as_bits(response_error)), 32'h1);
    @(negedge clock);
    expect_register("REG_ERRORS", capi_response_pkg::REG_ERRORS, 32'h1);
    axi_write(capi_response_pkg::REG_ERRORS, 32'h7F);
    send_response(8'h71, capi_response_pkg::RSP_DONE, 1'b0);
    repeat (3) @(negedge clock);
    check("response_error", 32'(errors_as_bits(response_error)), 32'h0);
    @(negedge clock);
    expect_register("REG_ERRORS", capi_response_pkg::REG_ERRORS, 32'h0);
  endtask

  task automatic test_disables();
    axi_write(capi_response_pkg::REG_CONTROL, 32'd2);
    issue_command(8'h80, capi_response_pkg::CMD_READ, 8'hB0);
    send_response(8'h80, capi_response_pkg::RSP_DONE, 1'b0);
    repeat (3) begin
      check("response_control_out", 32'(response_control_out), 32'd0);
      @(negedge clock);
    end
    check_counters();
    axi_write(capi_response_pkg::REG_CONTROL, 32'd1);
    send_response(8'h81, capi_response_pkg::RSP_FAULT, 1'b0);
    repeat (4) begin
      check("response_error", 32'(errors_as_bits(response_error)), 32'd0);
      @(negedge clock);
    end
    expect_register("REG_ERRORS", capi_response_pkg::REG_ERRORS, 32'd0);
  endtask

  task automatic test_random_pipeline();
    logic [7:0]                        tags  [RANDOM_COUNT];
    logic [7:0]                        cus   [RANDOM_COUNT];
    capi_response_pkg::cmd_type_t      cmds  [RANDOM_COUNT];
    capi_response_pkg::response_code_t codes [RANDOM_COUNT];
    logic                              flips [RANDOM_COUNT];
    logic [6:0]                        errs  [RANDOM_COUNT];
    logic [255:0]                      used;
    logic [6:0]                        sticky;
    logic [31:0]                       bits;
    int                                j;
    used   = '0;
    sticky = '0;
    axi_write(capi_response_pkg::REG_CONTROL, 32'd3);
    axi_write(capi_response_pkg::REG_ERRORS, 32'h7F);
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      // Outstanding tags must stay distinct
      do begin
        take_bits(8, bits);
      end while (used[bits[7:0]]);
      used[bits[7:0]] = 1'b1;
      tags[i] = bits[7:0];
      take_bits(2, bits);
      cmds[i] = capi_response_pkg::cmd_type_t'(3'(bits[1:0]) + 3'd1);
      take_bits(8, bits);
      cus[i] = bits[7:0];
      take_bits(3, bits);
      codes[i] = code_from_index(bits[2:0]);
      take_bits(3, bits);
      flips[i] = (bits[2:0] == 3'd0);
      errs[i]  = expected_code_bits(codes[i]) | {6'd0, flips[i]};
      sticky   = sticky | errs[i];
      count_expected[int'(cmds[i]) - 1] += 32'd1;
      issue_command(tags[i], cmds[i], cus[i]);
    end
    // Routed output trails the drive by two cycles and the error vector by four
    for (int k = 0; k < RANDOM_COUNT + 4; k++) begin
      j = k - 2;
      if (j >= 0 && j < RANDOM_COUNT) begin
        check("class flags", 32'(observed_flags), 32'(expected_flags(cmds[j])));
        check("response.tag", 32'(response_control_out.response.tag), 32'(tags[j]));
        check("response.cu_id", 32'(response_control_out.response.cu_id), 32'(cus[j]));
      end
      j = k - 4;
      if (j >= 0) begin
        check("response_error", 32'(errors_as_bits(response_error)), 32'(errs[j]));
      end
      if (k < RANDOM_COUNT) begin
        drive_response(tags[k], codes[k], flips[k]);
      end else begin
        response.valid = 1'b0;
      end
      @(negedge clock);
    end
    @(negedge clock);
    check_counters();
    expect_register("REG_LAST_RESPONSE", capi_response_pkg::REG_LAST_RESPONSE,
                    last_response_word(tags[RANDOM_COUNT-1], cus[RANDOM_COUNT-1],
                                       cmds[RANDOM_COUNT-1], codes[RANDOM_COUNT-1]));
    expect_register("REG_ERRORS", capi_response_pkg::REG_ERRORS, 32'(sticky));
  endtask

  initial begin
    clock         = 1'b0;
    rstn          = 1'b0;
    command_issue = '0;
    response      = '0;
    axi_req       = '0;
    error_count   = 0;
    cycle_count   = 0;
    lfsr_state    = 32'h425d9855;
    for (int i = 0; i < 4; i++) begin
      count_expected[i] = 32'd0;
    end
    repeat (4) @(negedge clock);
    rstn = 1'b1;
    @(negedge clock);
    test_registers();
    test_routing();
    test_error_codes();
    test_parity();
    test_disables();
    test_random_pipeline();
    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== capi_response.f ====
capi_response_pkg.sv
command_tag_table.sv
response_control.sv
capi_status_regs.sv
capi_response_top.sv
capi_response_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = capi_response_tb
FILELIST  = capi_response.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
